// ==== source/nes_bus_pkg.sv ====
package nes_bus_pkg;

	// CPU side bus widths
	localparam int ADDR_WIDTH = 16;
	localparam int DATA_WIDTH = 8;

	typedef logic [ADDR_WIDTH-1:0] addr_t; // 6502 address space
	typedef logic [DATA_WIDTH-1:0] data_t; // One byte on the data bus

	// Fixed registers in the CPU memory map

	// Write of the source page here kicks off sprite DMA
	localparam addr_t OAM_DMA_ADDR = 16'h4014;

	// PPU OAM data port, every sprite DMA write lands here
	localparam addr_t OAM_DATA_ADDR = 16'h2004;

endpackage

// ==== source/nes_dma_pkg.sv ====
package nes_dma_pkg;

	// Sprite DMA engine
	typedef enum logic [1:0] {
		SPR_IDLE  = 2'd0, // No transfer pending
		SPR_ALIGN = 2'd1, // CPU paused, wait for read on odd cycle
		SPR_XFER  = 2'd3  // Even read, odd write to OAM
	} spr_state_t;

	// DMC sample fetch slot
	typedef enum logic {
		DMC_IDLE  = 1'b0, // Nothing to fetch
		DMC_FETCH = 1'b1  // Fetch granted, waits for the next even cycle
	} dmc_state_t;

	// Master clocks per CPU tick on NTSC
	localparam int DEFAULT_CPU_DIVIDE = 12;

endpackage

// ==== source/dma_bus_if.sv ====
`timescale 1ns/1ps

interface dma_bus_if import nes_bus_pkg::*; ();

	addr_t addr;   // Address the DMA engine wants on the bus
	logic  enable; // DMA is bus master this CPU cycle
	logic  read;   // High on even cycles for a read, low for a write
	data_t wdata;  // Latched sprite byte for the OAM write
	data_t rdata;  // Byte returned from memory or open bus

	// DMA side requests the bus and takes the read data
	modport dma (
		output addr,
		output enable,
		output read,
		output wdata,
		input  rdata
	);

	// Arbiter side forwards the request and returns data
	modport arbiter (
		input  addr,
		input  enable,
		input  read,
		input  wdata,
		output rdata
	);

endinterface

// ==== source/cpu_clock_divider.sv ====
`timescale 1ns/1ps

module cpu_clock_divider import nes_dma_pkg::*; #(
	parameter int CPU_DIVIDE = DEFAULT_CPU_DIVIDE // Master clocks per CPU tick
) (
	input  logic clk,
	input  logic reset,
	output logic cpu_ce,    // One clk wide tick per CPU cycle
	output logic odd_cycle  // APU cycle parity, 1 is odd
);

	localparam int CNT_W = $clog2(CPU_DIVIDE);

	// Count value on which the tick fires
	localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'(CPU_DIVIDE - 1);

	logic [CNT_W-1:0] div_cnt; // Master clock position inside the CPU cycle

	// Tick on the last master clock of the cycle
	// Counter sits at zero in reset so the first tick is CPU_DIVIDE clks later
	assign cpu_ce = (div_cnt == LAST_COUNT);

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt   <= '0;
			odd_cycle <= 1'b1; // First CPU cycle after reset counts as odd
		end else begin
			if (cpu_ce)
				div_cnt <= '0; // Wrap
			else
				div_cnt <= div_cnt + 1'b1;

			// Parity flips once per CPU cycle
			// DMA reads on even cycles and writes on odd ones
			if (cpu_ce)
				odd_cycle <= ~odd_cycle;
		end
	end

endmodule

// ==== source/dma_controller.sv ====
`timescale 1ns/1ps

module dma_controller import nes_bus_pkg::*, nes_dma_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  cpu_ce,         // CPU cycle boundary
	input  logic  odd_cycle,      // Parity of the current CPU cycle
	input  logic  sprite_trigger, // CPU write to the OAM DMA register
	input  data_t page,           // Source page from the CPU write
	input  logic  cpu_read,       // CPU is in a read cycle
	input  logic  dmc_request,    // DMC wants a sample byte
	input  addr_t dmc_addr,       // Where the sample byte lives
	output logic  dmc_ack,        // Bus reads dmc_addr this cycle
	output logic  pause_cpu,      // Hold the CPU
	dma_bus_if.dma bus
);

	spr_state_t spr_state;
	dmc_state_t dmc_state;

	data_t src_page;   // High byte of the sprite source address
	data_t src_index;  // Low byte, walks 00 to FF
	data_t byte_latch; // Byte read on the even cycle, written on the odd one

	logic spr_start;   // Trigger accepted
	logic spr_read;    // Sprite read completes at this tick
	logic dmc_take;    // DMC slot granted at this tick
	logic last_byte;   // Index FF is in flight

	assign spr_start = (spr_state == SPR_IDLE) && sprite_trigger;
	assign spr_read  = (spr_state == SPR_XFER) && !odd_cycle && !dmc_ack;

	// Fetch only steals a CPU read cycle, granted at the end of an even cycle
	assign dmc_take  = (dmc_state == DMC_IDLE) && dmc_request && cpu_read && !odd_cycle;
	assign last_byte = (src_index == 8'hFF);

	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= SPR_IDLE;
			dmc_state <= DMC_IDLE;
			src_index <= '0;
		end else if (cpu_ce) begin
			// DMC slot, the fetch lands on the next even cycle
			if (dmc_state == DMC_IDLE) begin
				if (dmc_take)
					dmc_state <= DMC_FETCH;
			end else if (!odd_cycle) begin
				dmc_state <= DMC_IDLE; // Fetch cycle just ended
			end

			case (spr_state)
				SPR_IDLE: begin
					if (spr_start) begin
						spr_state <= SPR_ALIGN;
						src_index <= '0; // Always start at page:00
					end
				end
				SPR_ALIGN: begin
					// Next cycle is even so the first access is a read
					if (cpu_read && odd_cycle)
						spr_state <= SPR_XFER;
				end
				SPR_XFER: begin
					if (!odd_cycle && dmc_ack) begin
						// DMC took our read slot
						spr_state <= SPR_ALIGN; // Index unchanged, same byte again
					end else if (odd_cycle) begin
						src_index <= src_index + 1'b1; // OAM write done
						if (last_byte)
							spr_state <= SPR_IDLE;
					end
				end
				default: spr_state <= SPR_IDLE;
			endcase
		end
	end

	// Page and sprite byte
	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (spr_start)
				src_page <= page;
			if (spr_read)
				byte_latch <= bus.rdata; // Held for the odd cycle write
		end
	end

	assign dmc_ack   = (dmc_state == DMC_FETCH) && !odd_cycle;
	assign pause_cpu = (spr_state != SPR_IDLE) || dmc_request;

	// Bus request toward the arbiter
	assign bus.enable = dmc_ack || (spr_state == SPR_XFER);
	assign bus.read   = !odd_cycle; // Even read, odd write
	assign bus.wdata  = byte_latch;

	always_comb begin
		if (dmc_ack)
			bus.addr = dmc_addr;              // Sample fetch wins the even slot
		else if (!odd_cycle)
			bus.addr = {src_page, src_index}; // Sprite source read
		else
			bus.addr = OAM_DATA_ADDR;         // Sprite write to OAM
	end

endmodule

// ==== source/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter import nes_bus_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  addr_t cpu_addr,
	input  data_t cpu_dout,
	input  logic  cpu_rnw,        // CPU direction, high for read
	input  data_t mem_din,
	input  logic  mem_valid,      // Some memory drives the data bus
	output addr_t bus_addr,
	output data_t bus_dout,
	output logic  bus_read,
	output logic  bus_write,
	output data_t cpu_din,
	output logic  sprite_trigger, // CPU wrote the OAM DMA register
	output data_t page,           // Byte written there
	dma_bus_if.arbiter dma
);

	data_t open_bus; // Last value seen on the data bus
	data_t rdata;    // Read data back to CPU and DMA

	// Bus master select
	assign bus_addr  = dma.enable ? dma.addr  : cpu_addr;
	assign bus_dout  = dma.enable ? dma.wdata : cpu_dout;
	assign bus_read  = dma.enable ? dma.read  : cpu_rnw;
	assign bus_write = !bus_read;

	// Only a CPU write starts sprite DMA, DMA writes go to OAM data anyway
	assign sprite_trigger = !dma.enable && !cpu_rnw && (cpu_addr == OAM_DMA_ADDR);
	assign page           = cpu_dout;

	// Undriven bus floats at its last value
	always_comb begin
		if (reset)
			rdata = '0;
		else if (mem_valid)
			rdata = mem_din;
		else
			rdata = open_bus;
	end

	// Writes also leave their byte on the bus
	always_ff @(posedge clk) begin
		if (bus_write)
			open_bus <= bus_dout;
		else
			open_bus <= rdata;
	end

	assign cpu_din   = rdata;
	assign dma.rdata = rdata; // Same bus byte for the DMA latch

endmodule

// ==== source/nes_dma_bus.sv ====
`timescale 1ns/1ps

module nes_dma_bus import nes_bus_pkg::*, nes_dma_pkg::*; #(
	parameter int CPU_DIVIDE = DEFAULT_CPU_DIVIDE // Master clocks per CPU tick
) (
	input  logic  clk,
	input  logic  reset,
	input  addr_t cpu_addr,
	input  data_t cpu_dout,
	input  logic  cpu_rnw,
	input  data_t mem_din,
	input  logic  mem_valid,
	input  logic  dmc_request,
	input  addr_t dmc_addr,
	output logic  cpu_ce,
	output logic  pause_cpu,
	output logic  dmc_ack,
	output addr_t bus_addr,
	output data_t bus_dout,
	output logic  bus_read,
	output logic  bus_write,
	output data_t cpu_din
);

	logic  odd_cycle;      // APU cycle parity
	logic  sprite_trigger; // Decoded OAM DMA register write
	data_t page;           // Sprite source page

	dma_bus_if dma_bus ();  // DMA request to the arbiter

	cpu_clock_divider #(
		.CPU_DIVIDE (CPU_DIVIDE)
	) clocks (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.odd_cycle (odd_cycle)
	);

	dma_controller dma (
		.clk            (clk),
		.reset          (reset),
		.cpu_ce         (cpu_ce),
		.odd_cycle      (odd_cycle),
		.sprite_trigger (sprite_trigger),
		.page           (page),
		.cpu_read       (cpu_rnw),
		.dmc_request    (dmc_request),
		.dmc_addr       (dmc_addr),
		.dmc_ack        (dmc_ack),
		.pause_cpu      (pause_cpu),
		.bus            (dma_bus)
	);

	bus_arbiter arbiter (
		.clk            (clk),
		.reset          (reset),
		.cpu_addr       (cpu_addr),
		.cpu_dout       (cpu_dout),
		.cpu_rnw        (cpu_rnw),
		.mem_din        (mem_din),
		.mem_valid      (mem_valid),
		.bus_addr       (bus_addr),
		.bus_dout       (bus_dout),
		.bus_read       (bus_read),
		.bus_write      (bus_write),
		.cpu_din        (cpu_din),
		.sprite_trigger (sprite_trigger),
		.page           (page),
		.dma            (dma_bus)
	);

endmodule

// ==== bench/nes_dma_bus_properties.sv ====
`timescale 1ns/1ps

module nes_dma_bus_properties (
	input logic clk,
	input logic reset,
	input logic cpu_ce,
	input logic dmc_ack,
	input logic pause_cpu,
	input logic dma_enable, // DMA owns the bus
	input logic dma_read
);

	logic exp_odd; // Cycle parity counted here from the CPU ticks

	always_ff @(posedge clk) begin
		if (reset)
			exp_odd <= 1'b1; // First CPU cycle after reset is odd
		else if (cpu_ce)
			exp_odd <= ~exp_odd;
	end

	// Ack only opens on a CPU cycle boundary
	ack_starts_on_tick: assert property (@(posedge clk) disable iff (reset)
		$rose(dmc_ack) |-> $past(cpu_ce))
		else $error("dmc_ack rose between CPU ticks");

	// And closes at the end of that same CPU cycle
	ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
		(cpu_ce && dmc_ack) |=> !dmc_ack)
		else $error("dmc_ack held past one CPU cycle");

	ack_on_even: assert property (@(posedge clk) disable iff (reset)
		dmc_ack |-> !exp_odd)
		else $error("dmc_ack on an odd cycle");

	// Even read, odd write while DMA drives
	read_on_even: assert property (@(posedge clk) disable iff (reset)
		dma_enable |-> (dma_read == !exp_odd))
		else $error("DMA direction does not follow cycle parity");

	enable_pauses_cpu: assert property (@(posedge clk) disable iff (reset)
		dma_enable |-> pause_cpu)
		else $error("DMA owns the bus while the CPU runs");

endmodule

bind dma_controller nes_dma_bus_properties props (
	.clk        (clk),
	.reset      (reset),
	.cpu_ce     (cpu_ce),
	.dmc_ack    (dmc_ack),
	.pause_cpu  (pause_cpu),
	.dma_enable (bus.enable),
	.dma_read   (bus.read)
);

// ==== bench/nes_dma_bus_tb.sv ====
`timescale 1ns/1ps

module nes_dma_bus_tb import nes_bus_pkg::*, nes_dma_pkg::*; ();

	localparam int DIVIDE        = DEFAULT_CPU_DIVIDE;
	localparam int PASS_ACCESSES = 40;
	// Two sprite DMAs of about 520 CPU cycles at 12 clks, room for a third and the short tests
	localparam int CYCLE_LIMIT   = 60000;

	logic  clk;
	logic  reset;
	addr_t cpu_addr;
	data_t cpu_dout;
	logic  cpu_rnw;
	data_t mem_din;
	logic  mem_valid;
	logic  dmc_request;
	addr_t dmc_addr;
	logic  cpu_ce;
	logic  pause_cpu;
	logic  dmc_ack;
	addr_t bus_addr;
	data_t bus_dout;
	logic  bus_read;
	logic  bus_write;
	data_t cpu_din;

	data_t       mem [0:65535]; // 64 KB CPU address space model
	logic [31:0] rng_state;
	int          errors;
	int          checks;
	int          tests;
	int          start_errors; // Counts when the current test began
	int          start_checks;
	int          cycle_count;
	string       test_name;

	nes_dma_bus uut (
		.clk         (clk),
		.reset       (reset),
		.cpu_addr    (cpu_addr),
		.cpu_dout    (cpu_dout),
		.cpu_rnw     (cpu_rnw),
		.mem_din     (mem_din),
		.mem_valid   (mem_valid),
		.dmc_request (dmc_request),
		.dmc_addr    (dmc_addr),
		.cpu_ce      (cpu_ce),
		.pause_cpu   (pause_cpu),
		.dmc_ack     (dmc_ack),
		.bus_addr    (bus_addr),
		.bus_dout    (bus_dout),
		.bus_read    (bus_read),
		.bus_write   (bus_write),
		.cpu_din     (cpu_din)
	);

	// Memory answers every read within the cycle
	assign mem_din   = mem[bus_addr];
	assign mem_valid = bus_read;

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 25 MHz master clock
	end

	// Hard stop if a test never finishes
	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
		$display("STATUS: FAIL");
		$finish;
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic data_t random_byte();
		logic [31:0] r;
		r = next_random();
		return r[31:24]; // Upper bits have the longest period
	endfunction

	function automatic addr_t random_addr();
		data_t hi;
		hi = random_byte();
		return {hi, random_byte()};
	endfunction

	function automatic addr_t random_dmc_addr();
		addr_t a;
		a = random_addr();
		a[15] = 1'b1; // Samples live in 8000-FFFF
		return a;
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Mismatch in %s, %s: expected %0h, actual %0h", test_name, what,
				expected, actual);
		end
	endtask

	task automatic begin_test(input string name);
		test_name    = name;
		start_errors = errors;
		start_checks = checks;
		tests++;
	endtask

	task automatic end_test();
		$display("Test %s: %0d checks, %0d errors", test_name, checks - start_checks,
			errors - start_errors);
	endtask

	// Sample point, mid clk of a CPU tick
	task automatic wait_ce();
		@(negedge clk);
		while (!cpu_ce)
			@(negedge clk);
	endtask

	task automatic after_tick_edge();
		@(posedge clk);
		#2; // Inputs change just after the edge
	endtask

	task automatic record_write();
		if (bus_write)
			mem[bus_addr] = bus_dout;
	endtask

	task automatic test_reset_tick();
		begin_test("reset_tick");
		for (int n = 1; n <= 4 * DIVIDE; n++) begin
			@(negedge clk);
			check_value("cpu_ce", 32'((n % DIVIDE) == 0), 32'(cpu_ce));
			check_value("pause_cpu", 32'd0, 32'(pause_cpu));
			check_value("dmc_ack", 32'd0, 32'(dmc_ack));
			check_value("bus_write", 32'd0, 32'(bus_write)); // CPU idles on a read
			check_value("bus_read", 32'(cpu_rnw), 32'(bus_read));
		end
		end_test();
	endtask

	task automatic test_passthrough();
		addr_t addr;
		logic  rnw;
		data_t data;
		begin_test("passthrough");
		for (int i = 0; i < PASS_ACCESSES; i++) begin
			addr = random_addr();
			if (addr == OAM_DMA_ADDR)
				addr = addr + 16'd1; // No DMA in this test
			rnw  = (random_byte() >= 8'h80);
			data = random_byte();
			after_tick_edge();
			cpu_addr = addr;
			cpu_rnw  = rnw;
			cpu_dout = data;
			wait_ce();
			check_value("bus_addr", 32'(addr), 32'(bus_addr));
			check_value("bus_read", 32'(rnw), 32'(bus_read));
			check_value("bus_write", 32'(!rnw), 32'(bus_write));
			check_value("pause_cpu", 32'd0, 32'(pause_cpu));
			if (rnw)
				check_value("cpu_din", 32'(mem[addr]), 32'(cpu_din));
			else
				check_value("bus_dout", 32'(data), 32'(bus_dout));
			record_write();
		end
		end_test();
	endtask

	task automatic run_sprite_dma(input string name, input logic with_dmc);
		data_t page;
		addr_t hold_addr;   // CPU read held through the DMA
		int    idx;
		int    dmc_at;      // Index whose read raises dmc_request
		int    ack_count;
		logic  write_phase;
		logic  dmc_done;
		logic  cpu_on_bus;
		data_t exp_byte;
		begin_test(name);
		page      = random_byte();
		hold_addr = random_addr();
		while (hold_addr[15:8] == page)
			hold_addr = random_addr();
		dmc_at      = 64 + int'(random_byte() & 8'h7F);
		idx         = 0;
		ack_count   = 0;
		write_phase = 1'b0;
		dmc_done    = 1'b0;
		exp_byte    = '0;

		after_tick_edge();
		cpu_addr = OAM_DMA_ADDR;
		cpu_rnw  = 1'b0;
		cpu_dout = page;
		dmc_addr = random_dmc_addr();
		wait_ce();
		check_value("trigger write", 32'(OAM_DMA_ADDR), 32'(bus_addr));
		check_value("trigger bus_write", 32'd1, 32'(bus_write));
		check_value("pause before trigger", 32'd0, 32'(pause_cpu));
		record_write();
		after_tick_edge();
		cpu_addr = hold_addr; // Next CPU cycle is a read, it stalls there
		cpu_rnw  = 1'b1;

		while (idx < 256) begin
			wait_ce();
			check_value("pause_cpu", 32'd1, 32'(pause_cpu));
			cpu_on_bus = bus_read && (bus_addr == hold_addr);
			if (dmc_ack) begin
				ack_count++;
				check_value("dmc bus_addr", 32'(dmc_addr), 32'(bus_addr));
				check_value("dmc bus_read", 32'd1, 32'(bus_read));
				check_value("dmc cpu_din", 32'(mem[dmc_addr]), 32'(cpu_din));
				after_tick_edge();
				dmc_request = 1'b0; // One fetch only
			end else if (write_phase) begin
				check_value("oam bus_write", 32'd1, 32'(bus_write));
				check_value("oam bus_addr", 32'(OAM_DATA_ADDR), 32'(bus_addr));
				check_value("oam bus_dout", 32'(exp_byte), 32'(bus_dout));
				record_write();
				idx++;
				write_phase = 1'b0;
			end else if (!cpu_on_bus) begin
				// Anything but the stalled CPU read must be the next source byte
				check_value("src bus_read", 32'd1, 32'(bus_read));
				check_value("src bus_addr", 32'({page, 8'(idx)}), 32'(bus_addr));
				exp_byte    = mem[{page, 8'(idx)}];
				write_phase = 1'b1;
				if (with_dmc && !dmc_done && idx == dmc_at) begin
					after_tick_edge();
					dmc_request = 1'b1;
					dmc_done    = 1'b1;
				end
			end
		end

		wait_ce();
		check_value("pause after dma", 32'd0, 32'(pause_cpu));
		check_value("cpu back on bus", 32'(hold_addr), 32'(bus_addr));
		check_value("dmc_ack count", with_dmc ? 32'd1 : 32'd0, 32'(ack_count));
		end_test();
	endtask

	task automatic test_dmc_alone();
		addr_t hold_addr;
		int    ack_count;
		begin_test("dmc_alone");
		hold_addr = random_addr();
		ack_count = 0;
		after_tick_edge();
		cpu_addr    = hold_addr;
		cpu_rnw     = 1'b1;
		dmc_addr    = random_dmc_addr();
		dmc_request = 1'b1;
		while (ack_count == 0) begin
			wait_ce();
			check_value("pause_cpu", 32'd1, 32'(pause_cpu));
			if (dmc_ack) begin
				ack_count++;
				check_value("dmc bus_addr", 32'(dmc_addr), 32'(bus_addr));
				check_value("dmc bus_read", 32'd1, 32'(bus_read));
				check_value("dmc cpu_din", 32'(mem[dmc_addr]), 32'(cpu_din));
			end else begin
				check_value("cpu bus_addr", 32'(hold_addr), 32'(bus_addr)); // Stalled read
			end
		end
		after_tick_edge();
		dmc_request = 1'b0;
		wait_ce();
		check_value("pause after fetch", 32'd0, 32'(pause_cpu));
		check_value("dmc_ack after fetch", 32'd0, 32'(dmc_ack));
		check_value("cpu back on bus", 32'(hold_addr), 32'(bus_addr));
		end_test();
	endtask

	initial begin
		reset       = 1'b1;
		cpu_addr    = '0;
		cpu_dout    = '0;
		cpu_rnw     = 1'b1;
		dmc_request = 1'b0;
		dmc_addr    = '0;
		rng_state   = 32'h9780;
		errors      = 0;
		checks      = 0;
		tests       = 0;
		for (int i = 0; i < 65536; i++)
			mem[16'(i)] = random_byte(); // Every address gets its own random byte

		repeat (5) @(posedge clk);
		#2;
		reset = 1'b0;

		test_reset_tick();
		test_passthrough();
		run_sprite_dma("sprite_dma", 1'b0);
		run_sprite_dma("sprite_dma_dmc", 1'b1);
		test_dmc_alone();

		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== nes_dma_bus.f ====
source/nes_bus_pkg.sv
source/nes_dma_pkg.sv
source/dma_bus_if.sv
source/cpu_clock_divider.sv
source/dma_controller.sv
source/bus_arbiter.sv
source/nes_dma_bus.sv
bench/nes_dma_bus_properties.sv
bench/nes_dma_bus_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := nes_dma_bus_tb
FILELIST  := nes_dma_bus.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := STATUS: FAIL
PASS_MSG  := STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
